/* programInput.txt */
// Header at 0: store count, run count, then one enable pattern per run (0 asks for random stalls)
// Program at the reset vector 0x10; expected stores at 0x100 as address/data pairs
@000
00000025 00000003 FFFFFFFF 00000000 6DB6DB6D
@010
01000FFD 02000005
20120010 20121010 20122010 20123010 20124010 20125010 20126010 20127010
20128010 20129010 2012A010 2012B010 2012C010 2012D010 2012E010 2012F010
60210FFE 60211FFE 60212FFE 60213FFE 60214FFE 60215FFE 60216FFE 60217FFE
60218FFE 60219FFE 6021AFFE 6021BFFE 6021CFFE 6021DFFE 6021EFFE 6021FFFE
000007FF 30000020 3F000021 31000030 04000031 13000030 24300000
0F00003C 32000040 32000040 32000041 FFFFFFFF
@100
00000000 0000000D 00000000 00000015 00000000 00000012 00000000 00000001
00000000 00000000 00000000 FFFFFFB0 00000000 0000000F 00000000 00000010
00000000 00000010 00000000 00000008 00000000 00000008 00000000 00000008
00000000 00000017 00000000 0800000F 00000000 0000000F 00000000 00000000
00000000 FFFFFFFC 00000000 00000001 00000000 00000000 00000000 FFFFFFF3
00000000 00000000 00000000 FFFFFFFD 00000000 FFFFFFFD 00000000 FFFFFFFD
00000000 FFFFFFFC 00000000 FFFFFFFE 00000000 FFFFFFF8 00000000 00000004
00000000 00000001 00000000 FFFFFFFD 00000000 FFFFFFFC 00000000 00000000
00000020 00000000 00000021 00000035 00000030 FFFFFFFD 00000031 FFFFFFFD
00000041 00000005

/* vlog.f */
cpuPkg.sv
isaPkg.sv
instrDecoder.sv
regFile.sv
aluExec.sv
cpuCore.sv
dataMemory.sv
cpuSystem.sv
tbChecker.sv
tbCpuSystem.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tbCpuSystem
FLIST     ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "TEST OK" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing -f $(FLIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* tbCpuSystem.sv */
`timescale 1ns/1ps

module tbCpuSystem;

    localparam logic [8:0] EXP_BASE     = 9'h100; // Expected store pairs in the data file
    localparam int         HALT_TIMEOUT = 1000;
    localparam int         DRAIN_CYCLES = 20;

    logic            clk;
    logic            reset_n;
    logic            en;
    logic [31:0]     insnData;
    logic [31:0]     insnAddr;
    cpuPkg::memBus_t dataBus;
    logic            halt;

    logic [31:0] fileMem [512];
    logic [31:0] enPattern;
    logic [4:0]  patIdx;
    integer      seed;
    int          passCount;
    int          failCount;

    cpuSystem #(
        .RESET_VECTOR  (cpuPkg::DEFAULT_RESET_VECTOR),
        .MEM_ADDR_BITS (8)
    ) u_cpuSystem (
        .clk        (clk),
        .reset_n    (reset_n),
        .i_en       (en),
        .i_insnData (insnData),
        .o_insnAddr (insnAddr),
        .o_dataBus  (dataBus),
        .o_halt     (halt)
    );

    tbChecker u_tbChecker (
        .clk     (clk),
        .reset_n (reset_n),
        .i_en    (en),
        .i_bus   (dataBus),
        .i_halt  (halt)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Instruction model and enable stimulus for one falling edge
    task automatic applyInputs();
        logic [31:0] rnd;
        if (enPattern == '0) begin
            rnd = $random(seed);
            en  = |rnd[1:0]; // Low about one cycle in four
        end else begin
            en = enPattern[patIdx];
        end
        patIdx   = patIdx + 5'd1;
        insnData = fileMem[insnAddr[8:0]];
    endtask

    task automatic runProgram(input int run);
        int waitCount;
        bit resetOk;
        bit haltOk;
        bit ok;
        logic [31:0] haltAddr;
        enPattern = fileMem[9'(2 + run)];
        reset_n   = 1'b0;
        resetOk   = 1'b1;
        u_tbChecker.startRun();
        repeat (5) begin
            @(negedge clk);
            applyInputs();
        end
        reset_n = 1'b1;
        if (insnAddr !== cpuPkg::DEFAULT_RESET_VECTOR) begin
            $display("ERROR t=%0t o_insnAddr expected %h got %h", $time,
                     cpuPkg::DEFAULT_RESET_VECTOR, insnAddr);
            resetOk = 1'b0;
        end
        if (dataBus.wrEn !== 1'b0 || halt !== 1'b0) begin
            $display("run %0d: store strobe or halt active right after reset", run);
            resetOk = 1'b0;
        end
        patIdx = '0;
        applyInputs();
        for (waitCount = 0; waitCount < HALT_TIMEOUT && halt !== 1'b1; waitCount++) begin
            @(negedge clk);
            applyInputs();
        end
        haltOk   = (halt === 1'b1);
        haltAddr = insnAddr;
        if (!haltOk) begin
            $display("run %0d: halt not reached within %0d cycles", run, HALT_TIMEOUT);
        end
        repeat (DRAIN_CYCLES) begin // Neither a store nor the PC may move after halt
            @(negedge clk);
            applyInputs();
            if (haltOk && insnAddr !== haltAddr) begin
                $display("ERROR t=%0t o_insnAddr expected %h got %h", $time,
                         haltAddr, insnAddr);
                haltOk = 1'b0;
            end
        end
        if (haltOk && halt !== 1'b1) begin
            $display("run %0d: halt dropped without a reset", run);
            haltOk = 1'b0;
        end
        u_tbChecker.endRun(run, resetOk && haltOk, ok);
        if (ok) begin
            passCount++;
        end else begin
            failCount++;
        end
    endtask

    initial begin
        seed      = 32'h6eb37ef3;
        reset_n   = 1'b0;
        en        = 1'b0;
        insnData  = '0;
        enPattern = '1;
        patIdx    = '0;
        passCount = 0;
        failCount = 0;
        $readmemh("programInput.txt", fileMem);
        for (int i = 0; i < int'(fileMem[0]); i++) begin
            u_tbChecker.addExpected(fileMem[EXP_BASE + 9'(2 * i)],
                                    fileMem[EXP_BASE + 9'(2 * i + 1)]);
        end
        for (int run = 0; run < int'(fileMem[1]); run++) begin
            runProgram(run);
        end
        $display("runs passed %0d, failed %0d", passCount, failCount);
        if (failCount == 0 && passCount > 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

/* tbChecker.sv */
`timescale 1ns/1ps

module tbChecker (
    input logic            clk,
    input logic            reset_n,
    input logic            i_en,
    input cpuPkg::memBus_t i_bus,
    input logic            i_halt
);

    logic [31:0] expAddr [$];
    logic [31:0] expData [$];
    int          nextIdx;
    int          matchCount;
    int          runErrors;

    task automatic addExpected(input logic [31:0] addr, input logic [31:0] data);
        expAddr.push_back(addr);
        expData.push_back(data);
    endtask

    task automatic startRun();
        nextIdx    = 0;
        matchCount = 0;
        runErrors  = 0;
    endtask

    task automatic endRun(input int run, input bit otherOk, output bit ok);
        if (nextIdx < expAddr.size()) begin
            $display("run %0d: store missing at halt, only %0d of %0d seen",
                     run, nextIdx, expAddr.size());
            runErrors++;
        end
        ok = (runErrors == 0) && otherOk;
        $display("run %0d: %0d of %0d stores matched, %0s",
                 run, matchCount, expAddr.size(), ok ? "pass" : "fail");
    endtask

    // A store counts once on the enabled edge that ends write-back
    always @(posedge clk) begin
        if (reset_n && i_en && i_bus.wrEn) begin
            if (i_halt) begin
                $display("t=%0t: store issued while halted", $time);
                runErrors++;
            end
            if (nextIdx >= expAddr.size()) begin
                $display("t=%0t: unexpected extra store to address %h", $time, i_bus.addr);
                runErrors++;
            end else begin
                if (i_bus.addr !== expAddr[nextIdx]) begin
                    $display("ERROR t=%0t o_dataBus.addr expected %h got %h",
                             $time, expAddr[nextIdx], i_bus.addr);
                    runErrors++;
                end else if (i_bus.wrData !== expData[nextIdx]) begin
                    $display("ERROR t=%0t o_dataBus.wrData expected %h got %h",
                             $time, expData[nextIdx], i_bus.wrData);
                    runErrors++;
                end else begin
                    matchCount++;
                end
                nextIdx++;
            end
        end
    end

endmodule

/* cpuSystem.sv */
`timescale 1ns/1ps

module cpuSystem #(
    parameter logic [31:0] RESET_VECTOR  = cpuPkg::DEFAULT_RESET_VECTOR,
    parameter int          MEM_ADDR_BITS = 8
) (
    input  logic            clk,
    input  logic            reset_n,
    input  logic            i_en,
    input  logic [31:0]     i_insnData,
    output logic [31:0]     o_insnAddr,
    output cpuPkg::memBus_t o_dataBus,
    output logic            o_halt
);

    logic [31:0] memRdData;

    cpuCore #(
        .RESET_VECTOR (RESET_VECTOR)
    ) u_cpuCore (
        .clk         (clk),
        .reset_n     (reset_n),
        .i_en        (i_en),
        .i_insnData  (i_insnData),
        .i_memRdData (memRdData),
        .o_insnAddr  (o_insnAddr),
        .o_memBus    (o_dataBus),
        .o_halt      (o_halt)
    );

    dataMemory #(
        .MEM_ADDR_BITS (MEM_ADDR_BITS)
    ) u_dataMemory (
        .clk      (clk),
        .i_en     (i_en),
        .i_bus    (o_dataBus),
        .o_rdData (memRdData)
    );

endmodule

/* dataMemory.sv */
`timescale 1ns/1ps

module dataMemory #(
    parameter int MEM_ADDR_BITS = 8
) (
    input  logic            clk,
    input  logic            i_en,
    input  cpuPkg::memBus_t i_bus,
    output logic [31:0]     o_rdData
);

    localparam int DEPTH = 2 ** MEM_ADDR_BITS;

    logic [31:0]              mem [DEPTH];
    logic [MEM_ADDR_BITS-1:0] wordAddr;

    assign wordAddr = i_bus.addr[MEM_ADDR_BITS-1:0]; // Upper bits alias
    assign o_rdData = mem[wordAddr];

    always_ff @(posedge clk) begin
        if (i_en && i_bus.wrEn) begin
            mem[wordAddr] <= i_bus.wrData;
        end
    end

endmodule

/* cpuCore.sv */
`timescale 1ns/1ps

module cpuCore #(
    parameter logic [31:0] RESET_VECTOR = 32'h0
) (
    input  logic            clk,
    input  logic            reset_n,
    input  logic            i_en,
    input  logic [31:0]     i_insnData,
    input  logic [31:0]     i_memRdData,
    output logic [31:0]     o_insnAddr,
    output cpuPkg::memBus_t o_memBus,
    output logic            o_halt
);

    localparam int PH_DECODE = 0;
    localparam int PH_EXEC   = 1;
    localparam int PH_WB     = 2;

    isaPkg::decoded_t   dec;
    cpuPkg::haltCause_t haltCause;
    logic [2:0]         phase;
    logic [31:0]        pc;
    logic [31:0]        valX;
    logic [31:0]        valY;
    logic [31:0]        valZ;
    logic [31:0]        result;
    logic [31:0]        wbData;
    logic               regForm;
    logic               regWrite;
    logic               jump;

    instrDecoder u_instrDecoder (
        .i_insn (i_insnData),
        .o_dec  (dec)
    );

    regFile u_regFile (
        .clk      (clk),
        .reset_n  (reset_n),
        .i_en     (i_en),
        .i_wrEn   (regWrite),
        .i_idxX   (dec.x),
        .i_idxY   (dec.y),
        .i_idxZ   (dec.z),
        .i_wrData (wbData),
        .i_pc     (pc),
        .o_valX   (valX),
        .o_valY   (valY),
        .o_valZ   (valZ)
    );

    aluExec u_aluExec (
        .clk      (clk),
        .reset_n  (reset_n),
        .i_en     (i_en),
        .i_load   (phase[PH_EXEC]),
        .i_x      (valX),
        .i_y      (valY),
        .i_imm    (dec.imm),
        .i_format (dec.format),
        .i_op     (dec.op),
        .o_result (result)
    );

    assign regForm  = !dec.deref[1]; // Register update or load
    assign wbData   = (dec.deref == isaPkg::DEREF_LOAD) ? i_memRdData : result;
    assign jump     = regForm && dec.z == isaPkg::REG_PC;
    assign regWrite = phase[PH_WB] && regForm &&
                      dec.z != isaPkg::REG_ZERO && dec.z != isaPkg::REG_PC;

    always_comb begin
        o_memBus.wrEn   = phase[PH_WB] && dec.deref[1];
        o_memBus.addr   = '0;
        o_memBus.wrData = '0;
        if (dec.deref != isaPkg::DEREF_REG) begin
            o_memBus.addr = dec.deref[0] ? result : valZ;
        end
        if (dec.deref[1]) begin
            o_memBus.wrData = dec.deref[0] ? valZ : result;
        end
    end

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            phase     <= 3'b001;
            pc        <= RESET_VECTOR;
            haltCause <= '0;
        end else if (i_en && !o_halt) begin
            if (phase[PH_DECODE] && dec.illegal) begin
                haltCause[cpuPkg::HALT_ILLEGAL] <= 1'b1; // Phase stays in decode
            end else begin
                phase <= {phase[1:0], phase[2]};
            end
            if (phase[PH_WB]) begin
                pc <= jump ? wbData : pc + 32'd1;
            end
        end
    end

    assign o_insnAddr = pc;
    assign o_halt     = |haltCause;

    phaseOneHot: assert property (@(posedge clk) disable iff (!reset_n) $onehot(phase))
        else $error("cpuCore phase not one-hot: %b", phase);

endmodule

/* aluExec.sv */
`timescale 1ns/1ps

module aluExec (
    input  logic                          clk,
    input  logic                          reset_n,
    input  logic                          i_en,
    input  logic                          i_load,
    input  logic [31:0]                   i_x,
    input  logic [31:0]                   i_y,
    input  logic [isaPkg::IMM_BITS-1:0]   i_imm,
    input  logic                          i_format,
    input  isaPkg::aluOp_t                i_op,
    output logic [31:0]                   o_result
);

    logic [31:0] immExt;
    logic [31:0] operand;
    logic [31:0] addend;
    logic [31:0] opVal;
    logic        reserved;

    assign immExt  = {{(32-isaPkg::IMM_BITS){i_imm[isaPkg::IMM_BITS-1]}}, i_imm};
    assign operand = i_format ? immExt : i_y; // Format swaps operand and addend
    assign addend  = i_format ? i_y : immExt;

    always_comb begin
        opVal    = '0;
        reserved = 1'b0;
        case (i_op)
            isaPkg::OP_OR:   opVal = i_x | operand;
            isaPkg::OP_AND:  opVal = i_x & operand;
            isaPkg::OP_ADD:  opVal = i_x + operand;
            isaPkg::OP_MUL:  opVal = i_x * operand; // Low word only
            isaPkg::OP_SHL:  opVal = i_x << operand;
            isaPkg::OP_LT:   opVal = {32{$signed(i_x) < $signed(operand)}};
            isaPkg::OP_EQ:   opVal = {32{i_x == operand}};
            isaPkg::OP_GT:   opVal = {32{$signed(i_x) > $signed(operand)}};
            isaPkg::OP_ANDN: opVal = i_x & ~operand;
            isaPkg::OP_XOR:  opVal = i_x ^ operand;
            isaPkg::OP_SUB:  opVal = i_x - operand;
            isaPkg::OP_XNOR: opVal = i_x ^~ operand;
            isaPkg::OP_SHR:  opVal = i_x >> operand; // Logical
            isaPkg::OP_NE:   opVal = {32{i_x != operand}};
            default:         reserved = 1'b1;
        endcase
    end

    always_ff @(posedge clk) begin
        if (i_en && i_load) begin
            o_result <= reserved ? '0 : opVal + addend;
        end
    end

    resultKnown: assert property (@(posedge clk) disable iff (!reset_n)
        (i_en && i_load) |=> !$isunknown(o_result))
        else $error("aluExec result unknown after load");

endmodule

/* regFile.sv */
`timescale 1ns/1ps

module regFile (
    input  logic        clk,
    input  logic        reset_n,
    input  logic        i_en,
    input  logic        i_wrEn,
    input  logic [3:0]  i_idxX,
    input  logic [3:0]  i_idxY,
    input  logic [3:0]  i_idxZ,
    input  logic [31:0] i_wrData,
    input  logic [31:0] i_pc,
    output logic [31:0] o_valX,
    output logic [31:0] o_valY,
    output logic [31:0] o_valZ
);

    logic [31:0] regs [1:14];
    logic [31:0] pcNext;

    assign pcNext = i_pc + 32'd1; // What r15 reads as

    assign o_valX = (i_idxX == isaPkg::REG_ZERO) ? '0 :
                    (i_idxX == isaPkg::REG_PC)   ? pcNext : regs[i_idxX];
    assign o_valY = (i_idxY == isaPkg::REG_ZERO) ? '0 :
                    (i_idxY == isaPkg::REG_PC)   ? pcNext : regs[i_idxY];
    assign o_valZ = (i_idxZ == isaPkg::REG_ZERO) ? '0 :
                    (i_idxZ == isaPkg::REG_PC)   ? pcNext : regs[i_idxZ];

    always_ff @(posedge clk) begin
        if (i_en && i_wrEn && i_idxZ != isaPkg::REG_ZERO && i_idxZ != isaPkg::REG_PC) begin
            regs[i_idxZ] <= i_wrData;
        end
    end

    // Core must route r15 writes to the PC and drop r0 writes itself
    wrIdxLegal: assert property (@(posedge clk) disable iff (!reset_n)
        (i_en && i_wrEn) |-> (i_idxZ != isaPkg::REG_ZERO && i_idxZ != isaPkg::REG_PC))
        else $error("regFile write to fixed register %0d", i_idxZ);

endmodule

/* instrDecoder.sv */
`timescale 1ns/1ps

module instrDecoder (
    input  logic [31:0]      i_insn,
    output isaPkg::decoded_t o_dec
);

    always_comb begin
        o_dec.format  = i_insn[isaPkg::FORMAT_BIT];
        o_dec.deref   = i_insn[isaPkg::DEREF_LSB +: 2];
        o_dec.z       = i_insn[isaPkg::Z_LSB +: 4];
        o_dec.x       = i_insn[isaPkg::X_LSB +: 4];
        o_dec.y       = i_insn[isaPkg::Y_LSB +: 4];
        o_dec.op      = isaPkg::aluOp_t'(i_insn[isaPkg::OP_LSB +: 4]);
        o_dec.imm     = i_insn[0 +: isaPkg::IMM_BITS];
        o_dec.illegal = &i_insn; // All ones traps
    end

endmodule

/* isaPkg.sv */
package isaPkg;

    // Bit positions inside the 32-bit instruction word
    localparam int FORMAT_BIT = 30;
    localparam int DEREF_LSB  = 28;
    localparam int Z_LSB      = 24;
    localparam int X_LSB      = 20;
    localparam int Y_LSB      = 16;
    localparam int OP_LSB     = 12;
    localparam int IMM_BITS   = 12;

    // Register indices with fixed meaning
    localparam logic [3:0] REG_ZERO = 4'd0;
    localparam logic [3:0] REG_PC   = 4'd15;

    // Dereference forms
    localparam logic [1:0] DEREF_REG     = 2'b00; // Z <- result
    localparam logic [1:0] DEREF_LOAD    = 2'b01; // Z <- mem[result]
    localparam logic [1:0] DEREF_STZADDR = 2'b10; // mem[Z] <- result
    localparam logic [1:0] DEREF_STRES   = 2'b11; // mem[result] <- Z

    // Codes 4 and 15 reserved
    typedef enum logic [3:0] {
        OP_OR   = 4'd0,
        OP_AND  = 4'd1,
        OP_ADD  = 4'd2,
        OP_MUL  = 4'd3,
        OP_SHL  = 4'd5,
        OP_LT   = 4'd6,
        OP_EQ   = 4'd7,
        OP_GT   = 4'd8,
        OP_ANDN = 4'd9,
        OP_XOR  = 4'd10,
        OP_SUB  = 4'd11,
        OP_XNOR = 4'd12,
        OP_SHR  = 4'd13,
        OP_NE   = 4'd14
    } aluOp_t;

    typedef struct packed {
        logic                format;  // Clear selects operand Y and addend imm
        logic [1:0]          deref;
        logic [3:0]          z;
        logic [3:0]          x;
        logic [3:0]          y;
        aluOp_t              op;
        logic [IMM_BITS-1:0] imm;
        logic                illegal;
    } decoded_t;

endpackage

/* cpuPkg.sv */
package cpuPkg;

    // Data-side bus where write and read share one address
    typedef struct packed {
        logic        wrEn;
        logic [31:0] addr;
        logic [31:0] wrData;
    } memBus_t;

    // One bit per halt cause
    localparam int HALT_CAUSE_BITS = 1;
    localparam int HALT_ILLEGAL    = 0;

    typedef logic [HALT_CAUSE_BITS-1:0] haltCause_t;

    // First instruction fetched after reset
    localparam logic [31:0] DEFAULT_RESET_VECTOR = 32'h0000_0010;

endpackage
